// File: list.f
hdl/qpu_pkg.sv
hdl/qpu_exu_decode.sv
hdl/qpu_exu_disp.sv
hdl/qpu_exu_alu.sv
hdl/qpu_exu_oitf.sv
hdl/qpu_exu_regfile.sv
hdl/qpu_exu_top.sv
bench/tb_qpu_exu.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the execution unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_qpu_exu -Mdir obj_dir -f list.f
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/Vtb_qpu_exu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q ">>> FAIL" sim.log; then
  exit 1
fi
exit 0

// File: bench/tb_qpu_exu.sv
`timescale 1ns/10ps

module tb_qpu_exu;

  logic               clk;
  logic               i_reset;
  logic               i_instr_valid;
  logic               o_instr_ready;
  qpu_pkg::instr_t    i_instr;
  logic               o_evt_valid;
  logic               i_evt_ready;
  qpu_pkg::evt_t      o_evt;
  logic               i_meas_valid;
  qpu_pkg::meas_rsp_t i_meas;

  // Reference model state
  logic [31:0]        mregs [16];
  qpu_pkg::time_t     mtime;
  qpu_pkg::qmask_t    mmrf;
  qpu_pkg::qmask_t    meas_q [$];  // Oldest first
  qpu_pkg::qmask_t    head_mask;
  qpu_pkg::evt_t      exp_q [$];
  int                 quant_cnt = 0;

  // Registered copies seen by the assertions
  qpu_pkg::qmask_t    pend_q    = '0;
  int                 outst_q   = 0;
  int                 quant_q   = 0;

  int                 errs      = 0;
  int                 touts     = 0;
  logic               meas_hold;
  int                 meas_delay;
  qpu_pkg::instr_t    prog [$];

  logic [3:0]         cur_op;
  logic [2:0]         cur_qidx;
  logic               cur_fmr;
  logic               cur_classic;

  assign cur_op      = i_instr.opcode;
  assign cur_qidx    = i_instr.imm[2:0];
  assign cur_fmr     = (cur_op == qpu_pkg::OP_FMR);
  assign cur_classic = !cur_fmr && (cur_op != qpu_pkg::OP_QOP) &&
                       (cur_op != qpu_pkg::OP_MEASURE);

  qpu_exu_top i_dut (
    .clk           (clk),
    .i_reset       (i_reset),
    .i_instr_valid (i_instr_valid),
    .o_instr_ready (o_instr_ready),
    .i_instr       (i_instr),
    .o_evt_valid   (o_evt_valid),
    .i_evt_ready   (i_evt_ready),
    .o_evt         (o_evt),
    .i_meas_valid  (i_meas_valid),
    .i_meas        (i_meas)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //////////////////////////////
  // Reference model
  //////////////////////////////
  function automatic qpu_pkg::instr_t make_instr(input logic [3:0] op, input logic [3:0] rd,
                                                 input logic [3:0] rs1, input logic [3:0] rs2,
                                                 input logic [15:0] imm);
    qpu_pkg::instr_t w;
    w.opcode = op;
    w.rd     = rd;
    w.rs1    = rs1;
    w.rs2    = rs2;
    w.imm    = imm;
    return w;
  endfunction

  function automatic qpu_pkg::qmask_t pending_mask();
    qpu_pkg::qmask_t m;
    m = '0;
    foreach (meas_q[i])
      m = m | meas_q[i];
    return m;
  endfunction

  task automatic reset_model();
    foreach (mregs[i])
      mregs[i] = '0;
    mtime     = '0;
    mmrf      = '0;
    quant_cnt = 0;
    meas_q.delete();
    exp_q.delete();
  endtask

  task automatic apply_instr(input qpu_pkg::instr_t w);
    qpu_pkg::evt_t e;
    logic [31:0]   simm;
    simm = {{16{w.imm[15]}}, w.imm};
    case (w.opcode)
      qpu_pkg::OP_ADDI: if (w.rd != 4'd0) mregs[w.rd] = mregs[w.rs1] + simm;
      qpu_pkg::OP_ADD:  if (w.rd != 4'd0) mregs[w.rd] = mregs[w.rs1] + mregs[w.rs2];
      qpu_pkg::OP_QWAIT: mtime = mtime + w.imm;             // Wraps at 2^16
      qpu_pkg::OP_QOP, qpu_pkg::OP_MEASURE:
      begin
        e.time_stamp = mtime;
        e.op         = (w.opcode == qpu_pkg::OP_MEASURE) ? qpu_pkg::EVT_MEASURE
                                                         : qpu_pkg::EVT_GATE;
        e.gate       = w.imm[7:0];
        e.mask       = mregs[w.rs1][7:0];
        exp_q.push_back(e);
        quant_cnt++;
        if (w.opcode == qpu_pkg::OP_MEASURE)
          meas_q.push_back(e.mask);
      end
      qpu_pkg::OP_FMR: if (w.rd != 4'd0) mregs[w.rd] = {31'd0, mmrf[w.imm[2:0]]};
      default: ;                                            // NOP
    endcase
  endtask

  task automatic compare_event();
    qpu_pkg::evt_t e;
    if (exp_q.size() == 0)
    begin
      errs++;
      $display("ERROR: event %h was sent although no event was expected", o_evt);
    end
    else
    begin
      e = exp_q.pop_front();
      assert (o_evt == e)
      else
      begin
        errs++;
        $display("CHECK FAILED o_evt exp %h got %h", e, o_evt);
      end
    end
  endtask

  always @(posedge clk)
  begin
    if (i_reset)
      reset_model();
    else
    begin
      if (o_evt_valid && i_evt_ready)
        compare_event();
      if (i_instr_valid && o_instr_ready)
        apply_instr(i_instr);
      if (i_meas_valid && (meas_q.size() > 0))
      begin
        head_mask = meas_q.pop_front();
        for (int q = 0; q < 8; q++)
          if (head_mask[q])
            mmrf[q] = i_meas.value[q];  // Oldest measure's qubits
      end
    end
    pend_q  <= pending_mask();
    outst_q <= meas_q.size();
    quant_q <= quant_cnt;
  end

  //////////////////////////////
  // Protocol and hazard checks
  //////////////////////////////
  a_evt_idle: assert property (@(posedge clk) disable iff (i_reset)
    (quant_q == 0) |-> !o_evt_valid)
  else
  begin
    errs++;
    $display("CHECK FAILED o_evt_valid exp %h got %h", 1'b0, o_evt_valid);
  end

  a_evt_hold: assert property (@(posedge clk) disable iff (i_reset)
    (o_evt_valid && !i_evt_ready) |=> (o_evt_valid && $stable(o_evt)))
  else
  begin
    errs++;
    $display("CHECK FAILED o_evt not held under back-pressure, valid %h evt %h",
             o_evt_valid, o_evt);
  end

  a_classic_go: assert property (@(posedge clk) disable iff (i_reset)
    (i_instr_valid && cur_classic) |-> o_instr_ready)
  else
  begin
    errs++;
    $display("CHECK FAILED o_instr_ready exp %h got %h, instr %h", 1'b1, o_instr_ready, i_instr);
  end

  a_fmr_wait: assert property (@(posedge clk) disable iff (i_reset)
    (i_instr_valid && cur_fmr && pend_q[cur_qidx]) |-> !o_instr_ready)
  else
  begin
    errs++;
    $display("CHECK FAILED o_instr_ready exp %h got %h, FMR %h", 1'b0, o_instr_ready, i_instr);
  end

  a_oitf_full: assert property (@(posedge clk) disable iff (i_reset)
    (i_instr_valid && (cur_op == qpu_pkg::OP_MEASURE) && (outst_q == 4)) |-> !o_instr_ready)
  else
  begin
    errs++;
    $display("CHECK FAILED o_instr_ready exp %h got %h, MEASURE %h", 1'b0, o_instr_ready,
             i_instr);
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////
  always @(posedge clk)
    i_evt_ready <= (($urandom % 2) == 0);

  // Results come back in order after a random delay
  initial
  begin
    forever
    begin
      @(negedge clk);
      if (!i_reset && !meas_hold && (outst_q > 0))
      begin
        meas_delay = 1 + int'($urandom % 6);
        repeat (meas_delay) @(posedge clk);
        i_meas_valid <= 1'b1;
        i_meas.value <= 8'($urandom);
        @(posedge clk);
        i_meas_valid <= 1'b0;
      end
    end
  end

  // Call right after a rising edge
  task automatic issue_instr(input qpu_pkg::instr_t w);
    int n;
    n = 0;
    i_instr_valid <= 1'b1;
    i_instr       <= w;
    @(negedge clk);
    while (!o_instr_ready && (n < 200))
    begin
      @(negedge clk);
      n++;
    end
    if (!o_instr_ready)
    begin
      touts++;
      $display("ERROR: instruction %h was not accepted within 200 cycles", w);
    end
    @(posedge clk);   // Accepting edge
    i_instr_valid <= 1'b0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    @(negedge clk);
    while (((exp_q.size() != 0) || (meas_q.size() != 0)) && (n < 400))
    begin
      @(negedge clk);
      n++;
    end
    if ((exp_q.size() != 0) || (meas_q.size() != 0))
    begin
      touts++;
      $display("ERROR: events or measurements still outstanding after 400 cycles");
    end
  endtask

  task automatic check_final_state();
    for (int i = 0; i < 16; i++)
    begin
      assert (i_dut.u_regfile.crf[i] == mregs[i])
      else
      begin
        errs++;
        $display("CHECK FAILED crf[%0d] exp %h got %h", i, mregs[i], i_dut.u_regfile.crf[i]);
      end
    end
    assert (i_dut.u_regfile.time_q == mtime)
    else
    begin
      errs++;
      $display("CHECK FAILED time_q exp %h got %h", mtime, i_dut.u_regfile.time_q);
    end
  endtask

  initial
  begin
    void'($urandom(32'h3695948b));
    i_reset       = 1'b1;
    i_instr_valid = 1'b0;
    i_instr       = '0;
    i_evt_ready   = 1'b0;
    i_meas_valid  = 1'b0;
    i_meas        = '0;
    meas_hold     = 1'b0;

    // Classical chains, gates, waits and measure/FMR pairs
    prog.push_back(make_instr(qpu_pkg::OP_ADDI, 4'd1, 4'd0, 4'd0, 16'h0005));
    prog.push_back(make_instr(qpu_pkg::OP_ADDI, 4'd2, 4'd0, 4'd0, 16'hFFFD));
    prog.push_back(make_instr(qpu_pkg::OP_ADD, 4'd3, 4'd1, 4'd2, 16'h0000));
    prog.push_back(make_instr(qpu_pkg::OP_ADDI, 4'd3, 4'd3, 4'd0, 16'h00A5));
    prog.push_back(make_instr(qpu_pkg::OP_QOP, 4'd0, 4'd3, 4'd0, 16'h0012));
    prog.push_back(make_instr(qpu_pkg::OP_QWAIT, 4'd0, 4'd0, 4'd0, 16'h000A));
    prog.push_back(make_instr(qpu_pkg::OP_QOP, 4'd0, 4'd3, 4'd0, 16'h0034));
    prog.push_back(make_instr(qpu_pkg::OP_ADDI, 4'd4, 4'd0, 4'd0, 16'h000F));
    prog.push_back(make_instr(qpu_pkg::OP_QOP, 4'd0, 4'd4, 4'd0, 16'h0056));
    prog.push_back(make_instr(qpu_pkg::OP_ADD, 4'd5, 4'd4, 4'd3, 16'h0000));
    prog.push_back(make_instr(qpu_pkg::OP_QWAIT, 4'd0, 4'd0, 4'd0, 16'hFFF8));
    prog.push_back(make_instr(4'hF, 4'd9, 4'd1, 4'd1, 16'h1234));
    prog.push_back(make_instr(qpu_pkg::OP_ADDI, 4'd6, 4'd0, 4'd0, 16'h0001));
    prog.push_back(make_instr(qpu_pkg::OP_MEASURE, 4'd0, 4'd6, 4'd0, 16'h0000));
    prog.push_back(make_instr(qpu_pkg::OP_FMR, 4'd7, 4'd0, 4'd0, 16'h0000));
    prog.push_back(make_instr(qpu_pkg::OP_QOP, 4'd0, 4'd7, 4'd0, 16'h0077));
    prog.push_back(make_instr(qpu_pkg::OP_ADDI, 4'd6, 4'd0, 4'd0, 16'h000C));
    prog.push_back(make_instr(qpu_pkg::OP_MEASURE, 4'd0, 4'd6, 4'd0, 16'h0000));
    prog.push_back(make_instr(qpu_pkg::OP_FMR, 4'd8, 4'd0, 4'd0, 16'h0003));
    prog.push_back(make_instr(qpu_pkg::OP_ADDI, 4'd8, 4'd8, 4'd0, 16'h0010));
    prog.push_back(make_instr(qpu_pkg::OP_QOP, 4'd0, 4'd8, 4'd0, 16'h0078));
    for (int i = 0; i < 12; i++)
    begin
      prog.push_back(make_instr(qpu_pkg::OP_QOP, 4'd0, 4'(1 + i % 5), 4'd0, 16'($urandom)));
      prog.push_back(make_instr(qpu_pkg::OP_QWAIT, 4'd0, 4'd0, 4'd0, 16'($urandom)));
      prog.push_back(make_instr(qpu_pkg::OP_ADDI, 4'd9, 4'd9, 4'd0, 16'(i)));
    end

    repeat (2) @(posedge clk);
    i_reset <= 1'b0;
    foreach (prog[i])
      issue_instr(prog[i]);
    wait_drain();

    // Fill the measure table, then release the results
    @(posedge clk);
    meas_hold <= 1'b1;
    issue_instr(make_instr(qpu_pkg::OP_ADDI, 4'd10, 4'd0, 4'd0, 16'h0010));
    repeat (4) issue_instr(make_instr(qpu_pkg::OP_MEASURE, 4'd0, 4'd10, 4'd0, 16'h0000));
    fork
      issue_instr(make_instr(qpu_pkg::OP_MEASURE, 4'd0, 4'd10, 4'd0, 16'h0000));
      begin
        repeat (8) @(posedge clk);
        meas_hold <= 1'b0;
      end
    join
    issue_instr(make_instr(qpu_pkg::OP_FMR, 4'd11, 4'd0, 4'd0, 16'h0004));
    issue_instr(make_instr(qpu_pkg::OP_QOP, 4'd0, 4'd11, 4'd0, 16'h0099));
    wait_drain();
    check_final_state();

    $display("Errors: %0d check failures, %0d timeouts", errs, touts);
    if ((errs == 0) && (touts == 0))
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

// File: hdl/qpu_exu_top.sv
`timescale 1ns/10ps

module qpu_exu_top (
  input  logic               clk,
  input  logic               i_reset,
  input  logic               i_instr_valid,
  output logic               o_instr_ready,
  input  qpu_pkg::instr_t    i_instr,
  output logic               o_evt_valid,
  input  logic               i_evt_ready,
  output qpu_pkg::evt_t      o_evt,
  input  logic               i_meas_valid,
  input  qpu_pkg::meas_rsp_t i_meas
);

  qpu_pkg::dec_info_t       dec;
  qpu_pkg::alu_req_t        req;
  logic                     fire;
  logic                     meas_alloc;
  qpu_pkg::qmask_t          meas_mask;
  logic                     oitf_full;
  qpu_pkg::qmask_t          pending;
  qpu_pkg::qmask_t          ret_mask;
  logic [qpu_pkg::XLEN-1:0] rs1;
  logic [qpu_pkg::XLEN-1:0] rs2;
  logic                     crf_wen;
  qpu_pkg::rfidx_t          crf_idx;
  logic [qpu_pkg::XLEN-1:0] crf_data;
  logic                     time_wen;
  qpu_pkg::time_t           time_wdata;
  qpu_pkg::time_t           time_cur;
  qpu_pkg::qmask_t          mrf;
  logic                     evt_busy;

  qpu_exu_decode u_decode (.i_instr (i_instr), .o_dec (dec));

  qpu_exu_disp u_disp (
    .i_instr_valid (i_instr_valid), .o_instr_ready (o_instr_ready),
    .i_dec         (dec),           .i_rs1         (rs1),
    .i_rs2         (rs2),           .i_evt_busy    (evt_busy),
    .i_oitf_full   (oitf_full),     .i_pending     (pending),
    .o_fire        (fire),          .o_req         (req),
    .o_meas_alloc  (meas_alloc),    .o_meas_mask   (meas_mask)
  );

  qpu_exu_alu u_alu (
    .clk        (clk),        .i_reset     (i_reset),     .i_fire      (fire),
    .i_req      (req),        .i_time      (time_cur),    .i_mrf       (mrf),
    .o_crf_wen  (crf_wen),    .o_crf_idx   (crf_idx),     .o_crf_data  (crf_data),
    .o_time_wen (time_wen),   .o_time      (time_wdata),  .o_evt_busy  (evt_busy),
    .o_evt_valid(o_evt_valid), .i_evt_ready (i_evt_ready), .o_evt       (o_evt)
  );

  qpu_exu_oitf u_oitf (
    .clk        (clk),        .i_reset      (i_reset),   .i_alloc   (meas_alloc),
    .i_alloc_mask (meas_mask), .i_ret       (i_meas_valid), .o_ret_mask (ret_mask),
    .o_full     (oitf_full),  .o_empty      (),          .o_pending (pending)
  );

  qpu_exu_regfile u_regfile (
    .clk        (clk),        .i_reset    (i_reset),     .i_rs1_idx (dec.rs1),
    .i_rs2_idx  (dec.rs2),    .o_rs1      (rs1),         .o_rs2     (rs2),
    .i_crf_wen  (crf_wen),    .i_crf_idx  (crf_idx),     .i_crf_data (crf_data),
    .i_time_wen (time_wen),   .i_time     (time_wdata),  .o_time    (time_cur),
    .i_mrf_wen  (i_meas_valid), .i_mrf_mask (ret_mask),  .i_meas    (i_meas),
    .o_mrf      (mrf)
  );

endmodule

// File: hdl/qpu_exu_regfile.sv
`timescale 1ns/10ps

module qpu_exu_regfile (
  input  logic                     clk,
  input  logic                     i_reset,
  input  qpu_pkg::rfidx_t          i_rs1_idx,
  input  qpu_pkg::rfidx_t          i_rs2_idx,
  output logic [qpu_pkg::XLEN-1:0] o_rs1,
  output logic [qpu_pkg::XLEN-1:0] o_rs2,
  input  logic                     i_crf_wen,
  input  qpu_pkg::rfidx_t          i_crf_idx,
  input  logic [qpu_pkg::XLEN-1:0] i_crf_data,
  input  logic                     i_time_wen,
  input  qpu_pkg::time_t           i_time,
  output qpu_pkg::time_t           o_time,
  input  logic                     i_mrf_wen,
  input  qpu_pkg::qmask_t          i_mrf_mask,
  input  qpu_pkg::meas_rsp_t       i_meas,
  output qpu_pkg::qmask_t          o_mrf
);

  logic [qpu_pkg::XLEN-1:0] crf [qpu_pkg::RF_NUM];
  qpu_pkg::time_t           time_q;
  qpu_pkg::qmask_t          mrf_q;

  //////////////////////////////
  // Classical registers
  //////////////////////////////
  always_ff @(posedge clk)
  begin
    if (i_reset)
    begin
      for (int i = 0; i < qpu_pkg::RF_NUM; i++)
        crf[i] <= '0;
    end
    else if (i_crf_wen && (i_crf_idx != '0)) // r0 stays zero
      crf[i_crf_idx] <= i_crf_data;
  end

  assign o_rs1 = crf[i_rs1_idx];
  assign o_rs2 = crf[i_rs2_idx];

  //////////////////////////////
  // Time and measurement
  //////////////////////////////
  always_ff @(posedge clk)
  begin
    if (i_reset)
      time_q <= '0;
    else if (i_time_wen)
      time_q <= i_time;
  end

  // Only the retired qubits take the new result
  always_ff @(posedge clk)
  begin
    if (i_reset)
      mrf_q <= '0;
    else if (i_mrf_wen)
      mrf_q <= (mrf_q & ~i_mrf_mask) | (i_meas.value & i_mrf_mask);
  end

  assign o_time = time_q;
  assign o_mrf  = mrf_q;

endmodule

// File: hdl/qpu_exu_oitf.sv
`timescale 1ns/10ps

module qpu_exu_oitf (
  input  logic            clk,
  input  logic            i_reset,
  input  logic            i_alloc,
  input  qpu_pkg::qmask_t i_alloc_mask,
  input  logic            i_ret,
  output qpu_pkg::qmask_t o_ret_mask,
  output logic            o_full,
  output logic            o_empty,
  output qpu_pkg::qmask_t o_pending
);

  qpu_pkg::qmask_t                  mask_mem [qpu_pkg::OITF_DEPTH];
  logic [qpu_pkg::OITF_DEPTH-1:0]   vld;
  logic [qpu_pkg::OITF_PTR_W-1:0]   wr_ptr;
  logic [qpu_pkg::OITF_PTR_W-1:0]   rd_ptr;
  logic                             ret_ena;

  assign o_full     = &vld;
  assign o_empty    = ~|vld;
  assign ret_ena    = i_ret && !o_empty;              // Stray results dropped
  assign o_ret_mask = ret_ena ? mask_mem[rd_ptr] : '0;

  always_ff @(posedge clk)
  begin
    if (i_reset)
    begin
      vld    <= '0;
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      if (i_alloc)
      begin
        vld[wr_ptr] <= 1'b1;
        wr_ptr      <= wr_ptr + 1'b1;
      end
      if (ret_ena)
      begin
        vld[rd_ptr] <= 1'b0; // Head pops in order
        rd_ptr      <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (i_alloc)
      mask_mem[wr_ptr] <= i_alloc_mask;
  end

  // OR of live entries
  always_comb
  begin
    o_pending = '0;
    for (int i = 0; i < qpu_pkg::OITF_DEPTH; i++)
      o_pending = o_pending | (mask_mem[i] & {qpu_pkg::QUBIT_NUM{vld[i]}});
  end

endmodule

// File: hdl/qpu_exu_alu.sv
`timescale 1ns/10ps

module qpu_exu_alu (
  input  logic                     clk,
  input  logic                     i_reset,
  input  logic                     i_fire,
  input  qpu_pkg::alu_req_t        i_req,
  input  qpu_pkg::time_t           i_time,
  input  qpu_pkg::qmask_t          i_mrf,
  output logic                     o_crf_wen,
  output qpu_pkg::rfidx_t          o_crf_idx,
  output logic [qpu_pkg::XLEN-1:0] o_crf_data,
  output logic                     o_time_wen,
  output qpu_pkg::time_t           o_time,
  output logic                     o_evt_busy,
  output logic                     o_evt_valid,
  input  logic                     i_evt_ready,
  output qpu_pkg::evt_t            o_evt
);

  qpu_pkg::opcode_e op;
  logic             is_quant;
  logic             evt_load;
  qpu_pkg::evt_t    evt_next;

  assign op       = i_req.dec.opcode;
  assign is_quant = (op == qpu_pkg::OP_QOP) || (op == qpu_pkg::OP_MEASURE);

  //////////////////////////////
  // Classical and time results
  //////////////////////////////
  always_comb
  begin
    case (op)
      qpu_pkg::OP_ADDI: o_crf_data = i_req.rs1 + i_req.dec.imm;
      qpu_pkg::OP_ADD:  o_crf_data = i_req.rs1 + i_req.rs2;
      qpu_pkg::OP_FMR:  o_crf_data = {{(qpu_pkg::XLEN-1){1'b0}}, i_mrf[i_req.dec.qidx]};
      default:          o_crf_data = '0;
    endcase
  end

  assign o_crf_wen  = i_fire && i_req.dec.rd_wen;
  assign o_crf_idx  = i_req.dec.rd;
  assign o_time_wen = i_fire && (op == qpu_pkg::OP_QWAIT);
  assign o_time     = i_time + i_req.dec.imm[qpu_pkg::TIME_W-1:0]; // Wraps at 2^16

  //////////////////////////////
  // Event output register
  //////////////////////////////
  always_comb
  begin
    evt_next.time_stamp = i_time;
    evt_next.op         = (op == qpu_pkg::OP_MEASURE) ? qpu_pkg::EVT_MEASURE
                                                      : qpu_pkg::EVT_GATE;
    evt_next.gate       = i_req.dec.gate;
    evt_next.mask       = i_req.rs1[qpu_pkg::QUBIT_NUM-1:0];
  end

  assign evt_load   = i_fire && is_quant;
  assign o_evt_busy = o_evt_valid && !i_evt_ready; // Frees on transfer

  always_ff @(posedge clk)
  begin
    if (i_reset)
      o_evt_valid <= 1'b0;
    else if (evt_load)
      o_evt_valid <= 1'b1;
    else if (i_evt_ready)
      o_evt_valid <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (evt_load)
      o_evt <= evt_next;
  end

endmodule

// File: hdl/qpu_exu_disp.sv
`timescale 1ns/10ps

module qpu_exu_disp (
  input  logic                     i_instr_valid,
  output logic                     o_instr_ready,
  input  qpu_pkg::dec_info_t       i_dec,
  input  logic [qpu_pkg::XLEN-1:0] i_rs1,
  input  logic [qpu_pkg::XLEN-1:0] i_rs2,
  input  logic                     i_evt_busy,
  input  logic                     i_oitf_full,
  input  qpu_pkg::qmask_t          i_pending,
  output logic                     o_fire,
  output qpu_pkg::alu_req_t        o_req,
  output logic                     o_meas_alloc,
  output qpu_pkg::qmask_t          o_meas_mask
);

  logic is_qop;
  logic is_meas;
  logic is_fmr;
  logic stall;

  assign is_qop  = (i_dec.opcode == qpu_pkg::OP_QOP);
  assign is_meas = (i_dec.opcode == qpu_pkg::OP_MEASURE);
  assign is_fmr  = (i_dec.opcode == qpu_pkg::OP_FMR);

  //////////////////////////////
  // Hazards
  //////////////////////////////
  // Event slot full, measure table full, or FMR qubit still in flight
  assign stall = ((is_qop || is_meas) && i_evt_busy) ||
                 (is_meas && i_oitf_full)            ||
                 (is_fmr && i_pending[i_dec.qidx]);

  assign o_instr_ready = !stall;
  assign o_fire        = i_instr_valid && !stall;

  //////////////////////////////
  // Issue
  //////////////////////////////
  always_comb
  begin
    o_req.dec = i_dec;
    o_req.rs1 = i_rs1;
    o_req.rs2 = i_rs2;
  end

  assign o_meas_alloc = o_fire && is_meas;
  assign o_meas_mask  = i_rs1[qpu_pkg::QUBIT_NUM-1:0]; // Mask from low rs1 bits

endmodule

// File: hdl/qpu_exu_decode.sv
`timescale 1ns/10ps

module qpu_exu_decode (
  input  qpu_pkg::instr_t    i_instr,
  output qpu_pkg::dec_info_t o_dec
);

  qpu_pkg::opcode_e opcode;

  //////////////////////////////
  // Opcode map
  //////////////////////////////
  always_comb
  begin
    case (i_instr.opcode)
      qpu_pkg::OP_ADDI:    opcode = qpu_pkg::OP_ADDI;
      qpu_pkg::OP_ADD:     opcode = qpu_pkg::OP_ADD;
      qpu_pkg::OP_QWAIT:   opcode = qpu_pkg::OP_QWAIT;
      qpu_pkg::OP_QOP:     opcode = qpu_pkg::OP_QOP;
      qpu_pkg::OP_MEASURE: opcode = qpu_pkg::OP_MEASURE;
      qpu_pkg::OP_FMR:     opcode = qpu_pkg::OP_FMR;
      default:             opcode = qpu_pkg::OP_NOP; // Still consumed
    endcase
  end

  //////////////////////////////
  // Field split
  //////////////////////////////
  always_comb
  begin
    o_dec.opcode = opcode;
    o_dec.rd     = i_instr.rd;
    o_dec.rs1    = i_instr.rs1;
    o_dec.rs2    = i_instr.rs2;

    // Only these write the classical file
    o_dec.rd_wen = (opcode == qpu_pkg::OP_ADDI) ||
                   (opcode == qpu_pkg::OP_ADD)  ||
                   (opcode == qpu_pkg::OP_FMR);

    o_dec.imm  = {{(qpu_pkg::XLEN - qpu_pkg::IMM_W){i_instr.imm[qpu_pkg::IMM_W-1]}},
                  i_instr.imm};
    o_dec.gate = i_instr.imm[qpu_pkg::GATE_W-1:0];
    o_dec.qidx = i_instr.imm[qpu_pkg::QIDX_W-1:0];
  end

endmodule

// File: hdl/qpu_pkg.sv
package qpu_pkg;

  localparam int XLEN       = 32;
  localparam int RF_NUM     = 16;
  localparam int RFIDX_W    = $clog2(RF_NUM);
  localparam int TIME_W     = 16;
  localparam int IMM_W      = 16;
  localparam int GATE_W     = 8;
  localparam int QUBIT_NUM  = 8;
  localparam int QIDX_W     = $clog2(QUBIT_NUM);
  localparam int OITF_DEPTH = 4;
  localparam int OITF_PTR_W = $clog2(OITF_DEPTH);

  typedef logic [RFIDX_W-1:0]   rfidx_t;
  typedef logic [TIME_W-1:0]    time_t;
  typedef logic [QUBIT_NUM-1:0] qmask_t;

  // Unlisted codes fall to OP_NOP
  typedef enum logic [3:0] {
    OP_NOP     = 4'h0,
    OP_ADDI    = 4'h1,
    OP_ADD     = 4'h2,
    OP_QWAIT   = 4'h3,
    OP_QOP     = 4'h4,
    OP_MEASURE = 4'h5,
    OP_FMR     = 4'h6
  } opcode_e;

  typedef enum logic {
    EVT_GATE    = 1'b0,
    EVT_MEASURE = 1'b1
  } evt_op_e;

  typedef struct packed {
    logic [3:0]       opcode;
    rfidx_t           rd;
    rfidx_t           rs1;
    rfidx_t           rs2;
    logic [IMM_W-1:0] imm;
  } instr_t;

  typedef struct packed {
    opcode_e           opcode;
    rfidx_t            rd;
    rfidx_t            rs1;
    rfidx_t            rs2;
    logic              rd_wen;
    logic [XLEN-1:0]   imm;    // Sign-extended
    logic [GATE_W-1:0] gate;
    logic [QIDX_W-1:0] qidx;   // FMR qubit
  } dec_info_t;

  typedef struct packed {
    dec_info_t       dec;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
  } alu_req_t;

  typedef struct packed {
    time_t             time_stamp;
    evt_op_e           op;
    logic [GATE_W-1:0] gate;
    qmask_t            mask;
  } evt_t;

  typedef struct packed {
    qmask_t value;  // One bit per qubit
  } meas_rsp_t;

endpackage
